// ==== Makefile ====
SRCS := $(wildcard rtl/*.sv) $(wildcard testbench/*.sv)

.PHONY: run clean

obj_dir/Vnes_bus_tb: compile.f $(SRCS)
	verilator --binary --timing -Wno-fatal -f compile.f --top-module nes_bus_tb -o Vnes_bus_tb

run: obj_dir/Vnes_bus_tb
	./obj_dir/Vnes_bus_tb | tee sim.log
	@if grep -q ">>> FAIL" sim.log; then exit 1; fi
	@grep -q ">>> PASS" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== compile.f ====
rtl/nes_bus_pkg.sv
rtl/clock_gen.sv
rtl/oam_dmc_dma.sv
rtl/bus_decoder.sv
rtl/io_regs.sv
rtl/read_data_mux.sv
rtl/nes_bus_top.sv
testbench/nes_bus_tb.sv

// ==== rtl/bus_decoder.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Bus decoder
// Picks the bus master and turns the address map
// into chip selects and slot timed device strobes
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module bus_decoder (
	input  wire nes_bus_pkg::ce_bundle_t ce,
	input  wire nes_bus_pkg::bus_req_t  cpu_req,
	input  wire nes_bus_pkg::bus_req_t  dma_req,
	input  wire                         dma_enable,
	output nes_bus_pkg::bus_req_t       bus,
	output nes_bus_pkg::dev_sel_t       sel,
	output logic                        oam_trigger,
	output logic                        ppu_read,
	output logic                        ppu_write,
	output logic                        prg_read,
	output logic                        prg_write,
	output logic [1:0]                  joypad_clock
);
	import nes_bus_pkg::*;

	logic in_ppu;
	logic in_apu;
	logic in_cart;
	logic joy1_hit;
	logic joy2_hit;

	// DMA owns the bus while enabled
	assign bus = dma_enable ? dma_req : cpu_req;

	assign in_ppu   = (bus.addr >= PPU_BASE) && (bus.addr <= PPU_END);
	assign in_apu   = (bus.addr >= APU_BASE) && (bus.addr <= APU_END);	// Joypads included
	assign in_cart  = !in_ppu && !in_apu;
	assign joy1_hit = (bus.addr == ADDR_JOY1);
	assign joy2_hit = (bus.addr == ADDR_JOY2);

	assign sel.apu_cs     = in_apu;
	assign sel.ppu_cs     = in_ppu;
	assign sel.joy1_cs    = joy1_hit;
	assign sel.joy2_cs    = joy2_hit;
	assign sel.apu_status = (bus.addr == ADDR_APU_STATUS);

	// Sprite DMA start
	assign oam_trigger = bus.wr && (bus.addr == ADDR_OAM_DMA);

	// PPU samples these on its own enable inside the slot
	assign ppu_read  = bus.rd && in_ppu && ce.ppu_rd_slot;
	assign ppu_write = bus.wr && in_ppu && ce.ppu_wr_slot;

	// Cart sees RAM and ROM space too, it decides what it answers
	assign prg_read  = bus.rd && in_cart && ce.cart_slot;
	assign prg_write = bus.wr && in_cart && ce.cart_slot;

	assign joypad_clock = {bus.rd && joy2_hit, bus.rd && joy1_hit};	// Shift on read

endmodule

`default_nettype wire

// ==== rtl/clock_gen.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Clock generator
// Master clock divider for the CPU, PPU and cart enables,
// PPU access slots and the odd/even CPU cycle flag
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module clock_gen #(
	parameter int PAL_EXTRA = 4	// Extra master clocks in every fifth PAL cycle
) (
	input  wire                        clk,
	input  wire                        reset,
	input  wire nes_bus_pkg::sys_type_e sys_type,
	output nes_bus_pkg::ce_bundle_t    ce
);
	import nes_bus_pkg::*;

	localparam int CPU_LONG = CPU_DIV + PAL_EXTRA;		// Long PAL cycle length
	localparam int CW = $clog2(CPU_LONG + 1);
	localparam int PW = $clog2(PPU_DIV + 1);
	localparam int TW = $clog2(CPU_LONG / PPU_DIV + 1);	// Enough for every tick in a long cycle

	logic [CW-1:0] div_cpu;		// Runs 1..cpu_len
	logic [PW-1:0] div_ppu;		// Runs 1..PPU_DIV
	logic [TW-1:0] ppu_tick;	// PPU ticks done in this CPU cycle
	logic [2:0]    pal_count;	// Position in the five cycle PAL group
	logic          odd_flag;
	sys_type_e     last_sys_type;

	logic          pal;
	logic          long_cycle;
	logic          realign;
	logic [CW-1:0] cpu_len;
	logic          cpu_tick;
	logic          ppu_pulse;
	logic          cart_slot;

	assign pal        = (sys_type == sys_pal);
	assign long_cycle = pal && (pal_count == 3'd4);	// Fifth PAL cycle is stretched
	assign cpu_len    = long_cycle ? CW'(CPU_LONG) : CW'(CPU_DIV);
	assign realign    = (sys_type != last_sys_type);

	// No enables on the realign clock
	assign cpu_tick  = (div_cpu == cpu_len) && !realign;
	assign ppu_pulse = (div_ppu == PW'(PPU_DIV)) && !realign;

	always_ff @(posedge clk) begin
		if (reset) begin
			div_cpu       <= CW'(1);
			div_ppu       <= PW'(1);
			ppu_tick      <= '0;
			pal_count     <= 3'd0;
			odd_flag      <= 1'b1;	// First cycle after reset counts as odd
			last_sys_type <= sys_type;
		end else begin
			last_sys_type <= sys_type;
			if (realign) begin
				// Restart all dividers in phase
				div_cpu   <= CW'(1);
				div_ppu   <= PW'(1);
				ppu_tick  <= '0;
				pal_count <= 3'd0;
			end else begin
				div_cpu <= cpu_tick ? CW'(1) : div_cpu + CW'(1);
				div_ppu <= ppu_pulse ? PW'(1) : div_ppu + PW'(1);

				if (cpu_tick)
					ppu_tick <= '0;		// Tick count restarts with each CPU cycle
				else if (ppu_pulse)
					ppu_tick <= ppu_tick + TW'(1);

				if (cpu_tick && pal)
					pal_count <= (pal_count == 3'd4) ? 3'd0 : pal_count + 3'd1;

				if (cpu_tick)
					odd_flag <= ~odd_flag;
			end
		end
	end

	// Long cycle gains a leading tick so the slots move up by one
	assign cart_slot = (ppu_tick == (long_cycle ? TW'(1) : TW'(0)));

	assign ce.cpu_ce      = cpu_tick;
	assign ce.ppu_ce      = ppu_pulse;
	assign ce.cart_ce     = cart_slot && ppu_pulse;	// Mapper clocked once per CPU cycle
	assign ce.cart_slot   = cart_slot;
	assign ce.ppu_wr_slot = cart_slot;			// Writes share the cart tick
	assign ce.ppu_rd_slot = (ppu_tick == (long_cycle ? TW'(2) : TW'(1)));
	assign ce.odd_cycle   = odd_flag;

endmodule

`default_nettype wire

// ==== rtl/io_regs.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// I/O registers
// Open bus latch and joypad strobe / 3D glasses bits
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module io_regs (
	input  wire                        clk,
	input  wire                        reset,
	input  wire nes_bus_pkg::bus_req_t bus,
	input  wire nes_bus_pkg::dev_sel_t sel,
	input  wire nes_bus_pkg::byte_t    rdata,
	output nes_bus_pkg::byte_t         open_bus,
	output logic [2:0]                 joypad_out,
	output logic                       lr3d
);

	always_ff @(posedge clk) begin
		if (reset) begin
			open_bus   <= 8'h00;
			joypad_out <= 3'b000;
			lr3d       <= 1'b0;
		end else begin
			open_bus <= rdata;	// Last value seen on the data bus
			if (bus.wr && sel.joy1_cs) begin
				joypad_out <= bus.wdata[2:0];	// Bit 0 strobes the pads
				lr3d       <= bus.wdata[1];	// Famicom 3D glasses shutter
			end
		end
	end

endmodule

`default_nettype wire

// ==== rtl/nes_bus_pkg.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// NES bus package
// Widths, address map, state encodings and the
// structs shared by the timing and bus glue blocks
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package nes_bus_pkg;

	typedef logic [15:0] cpu_addr_t;	// CPU address bus
	typedef logic [7:0]  byte_t;		// Data bus byte

	// Video standard picks the CPU cycle pattern
	typedef enum logic {
		sys_ntsc = 1'b0,
		sys_pal  = 1'b1
	} sys_type_e;

	// Sprite DMA states, bit 0 pauses the CPU and bit 1 owns the bus
	typedef enum logic [1:0] {
		spr_idle = 2'b00,
		spr_wait = 2'b01,
		spr_run  = 2'b11
	} dma_state_e;

	localparam int CPU_DIV = 12;	// Master clocks per CPU cycle
	localparam int PPU_DIV = 4;	// Master clocks per PPU cycle

	localparam cpu_addr_t ADDR_OAM_DATA   = 16'h2004;	// PPU sprite data port
	localparam cpu_addr_t ADDR_OAM_DMA    = 16'h4014;	// Sprite DMA page register
	localparam cpu_addr_t ADDR_APU_STATUS = 16'h4015;
	localparam cpu_addr_t ADDR_JOY1       = 16'h4016;	// Joypad 1 and strobe register
	localparam cpu_addr_t ADDR_JOY2       = 16'h4017;

	// Register regions, bounds inclusive
	localparam cpu_addr_t PPU_BASE = 16'h2000;
	localparam cpu_addr_t PPU_END  = 16'h3FFF;	// PPU regs mirrored every 8 bytes
	localparam cpu_addr_t APU_BASE = 16'h4000;
	localparam cpu_addr_t APU_END  = 16'h4017;

	// Clock enables and access slots from the clock generator
	typedef struct packed {
		logic cpu_ce;
		logic ppu_ce;
		logic cart_ce;
		logic cart_slot;	// PPU tick where the cart sees the bus
		logic ppu_rd_slot;
		logic ppu_wr_slot;
		logic odd_cycle;	// 1 on odd CPU cycles
	} ce_bundle_t;

	// One bus master request
	typedef struct packed {
		cpu_addr_t addr;
		byte_t     wdata;
		logic      rd;
		logic      wr;
	} bus_req_t;

	// Decoded chip selects
	typedef struct packed {
		logic apu_cs;
		logic ppu_cs;
		logic joy1_cs;
		logic joy2_cs;
		logic apu_status;
	} dev_sel_t;

endpackage

`default_nettype wire

// ==== rtl/nes_bus_top.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// NES bus top level
// System timing, DMA and CPU side bus glue
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module nes_bus_top #(
	parameter int PAL_EXTRA = 4
) (
	input  wire                         clk,
	input  wire                         reset,
	input  wire nes_bus_pkg::sys_type_e  sys_type,
	input  wire nes_bus_pkg::cpu_addr_t cpu_addr,
	input  wire nes_bus_pkg::byte_t     cpu_wdata,
	input  wire                         cpu_rnw,
	input  wire                         dmc_request,
	input  wire nes_bus_pkg::cpu_addr_t dmc_addr,
	input  wire nes_bus_pkg::byte_t     ppu_rdata,
	input  wire nes_bus_pkg::byte_t     apu_rdata,
	input  wire nes_bus_pkg::byte_t     cart_rdata,
	input  wire                         cart_drive,
	input  wire [4:0]                   joypad1_data,
	input  wire [4:0]                   joypad2_data,
	output logic                        cpu_ce,
	output logic                        ppu_ce,
	output logic                        cart_ce,
	output logic                        odd_cycle,
	output logic                        pause_cpu,
	output logic                        dmc_ack,
	output nes_bus_pkg::cpu_addr_t      bus_addr,
	output nes_bus_pkg::byte_t          bus_wdata,
	output logic                        ppu_read,
	output logic                        ppu_write,
	output logic                        prg_read,
	output logic                        prg_write,
	output nes_bus_pkg::byte_t          cpu_rdata,
	output logic [2:0]                  joypad_out,
	output logic [1:0]                  joypad_clock,
	output logic                        lr3d
);
	import nes_bus_pkg::*;

	ce_bundle_t ce;
	bus_req_t   cpu_req;
	bus_req_t   dma_req;
	bus_req_t   bus;
	dev_sel_t   sel;
	byte_t      open_bus;
	logic       dma_enable;
	logic       oam_trigger;

	assign cpu_req = '{addr: cpu_addr, wdata: cpu_wdata, rd: cpu_rnw, wr: !cpu_rnw};

	clock_gen #(.PAL_EXTRA(PAL_EXTRA)) u_clock_gen (
		.clk(clk), .reset(reset), .sys_type(sys_type), .ce(ce)
	);

	oam_dmc_dma u_dma (
		.clk(clk), .reset(reset), .ce(ce),
		.cpu_read(cpu_rnw), .cpu_wdata(cpu_wdata), .oam_trigger(oam_trigger),
		.dmc_request(dmc_request), .dmc_addr(dmc_addr), .rdata(cpu_rdata),
		.dma_req(dma_req), .dma_enable(dma_enable), .dmc_ack(dmc_ack), .pause_cpu(pause_cpu)
	);

	bus_decoder u_decoder (
		.ce(ce), .cpu_req(cpu_req), .dma_req(dma_req), .dma_enable(dma_enable),
		.bus(bus), .sel(sel), .oam_trigger(oam_trigger),
		.ppu_read(ppu_read), .ppu_write(ppu_write),
		.prg_read(prg_read), .prg_write(prg_write), .joypad_clock(joypad_clock)
	);

	io_regs u_io_regs (
		.clk(clk), .reset(reset), .bus(bus), .sel(sel), .rdata(cpu_rdata),
		.open_bus(open_bus), .joypad_out(joypad_out), .lr3d(lr3d)
	);

	read_data_mux u_read_mux (
		.sel(sel), .open_bus(open_bus),
		.ppu_rdata(ppu_rdata), .apu_rdata(apu_rdata), .cart_rdata(cart_rdata),
		.cart_drive(cart_drive), .joypad1_data(joypad1_data), .joypad2_data(joypad2_data),
		.rdata(cpu_rdata)
	);

	assign cpu_ce    = ce.cpu_ce;
	assign ppu_ce    = ce.ppu_ce;
	assign cart_ce   = ce.cart_ce;
	assign odd_cycle = ce.odd_cycle;
	assign bus_addr  = bus.addr;	// Address after DMA takeover
	assign bus_wdata = bus.wdata;

endmodule

`default_nettype wire

// ==== rtl/oam_dmc_dma.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Sprite and DMC DMA controller
// Steals CPU bus cycles for OAM copies and DMC sample fetches
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module oam_dmc_dma (
	input  wire                         clk,
	input  wire                         reset,
	input  wire nes_bus_pkg::ce_bundle_t ce,
	input  wire                         cpu_read,	// CPU is in a read cycle
	input  wire nes_bus_pkg::byte_t     cpu_wdata,	// Page number on a 4014 write
	input  wire                         oam_trigger,
	input  wire                         dmc_request,
	input  wire nes_bus_pkg::cpu_addr_t dmc_addr,
	input  wire nes_bus_pkg::byte_t     rdata,	// Byte returned by the read mux
	output nes_bus_pkg::bus_req_t       dma_req,
	output logic                        dma_enable,
	output logic                        dmc_ack,
	output logic                        pause_cpu
);
	import nes_bus_pkg::*;

	dma_state_e spr_state;
	logic       dmc_pending;	// DMC steal waiting for the next even cycle
	cpu_addr_t  spr_addr;		// Source page and byte index
	byte_t      spr_data;		// Held from the read to the write cycle

	logic even;
	logic spr_active;
	logic last_byte;

	assign even       = !ce.odd_cycle;
	assign spr_active = (spr_state == spr_run);
	assign last_byte  = (spr_addr[7:0] == 8'hFF);

	always_ff @(posedge clk) begin
		if (reset) begin
			spr_state   <= spr_idle;
			dmc_pending <= 1'b0;
		end else if (ce.cpu_ce) begin
			// DMC request only taken while the CPU reads on an even cycle
			if (!dmc_pending && dmc_request && cpu_read && even)
				dmc_pending <= 1'b1;
			else if (dmc_pending && even)
				dmc_pending <= 1'b0;	// Steal done this cycle

			case (spr_state)
				spr_wait: if (cpu_read && ce.odd_cycle) spr_state <= spr_run;
				spr_run: begin
					if (even && dmc_pending)
						spr_state <= spr_wait;	// DMC took the read, idle one pair
					else if (ce.odd_cycle && last_byte)
						spr_state <= spr_idle;
				end
				spr_idle: ;
				default: spr_state <= spr_idle;
			endcase

			if (oam_trigger)
				spr_state <= spr_wait;
		end
	end

	always_ff @(posedge clk) begin
		if (ce.cpu_ce) begin
			if (oam_trigger)
				spr_addr <= {cpu_wdata, 8'h00};
			else if (spr_active && ce.odd_cycle)
				spr_addr[7:0] <= spr_addr[7:0] + 8'd1;	// Next byte after each write
			if (spr_active && even)
				spr_data <= rdata;
		end
	end

	assign dmc_ack    = dmc_pending && even;
	assign dma_enable = dmc_ack || spr_active;
	assign pause_cpu  = (spr_state != spr_idle) || dmc_request;

	// Reads on even cycles and writes to the OAM port on odd ones
	assign dma_req.addr  = dmc_ack ? dmc_addr : (even ? spr_addr : ADDR_OAM_DATA);
	assign dma_req.wdata = spr_data;
	assign dma_req.rd    = dma_enable && even;
	assign dma_req.wr    = dma_enable && ce.odd_cycle;

endmodule

`default_nettype wire

// ==== rtl/read_data_mux.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Read data multiplexer
// Picks the byte seen by the CPU and DMA
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module read_data_mux (
	input  wire nes_bus_pkg::dev_sel_t sel,
	input  wire nes_bus_pkg::byte_t    open_bus,
	input  wire nes_bus_pkg::byte_t    ppu_rdata,
	input  wire nes_bus_pkg::byte_t    apu_rdata,
	input  wire nes_bus_pkg::byte_t    cart_rdata,
	input  wire                        cart_drive,	// Cart or RAM answers this address
	input  wire [4:0]                  joypad1_data,
	input  wire [4:0]                  joypad2_data,
	output nes_bus_pkg::byte_t         rdata
);

	always_comb begin
		if (sel.joy1_cs)
			rdata = {open_bus[7:5], joypad1_data};	// Top bits float
		else if (sel.joy2_cs)
			rdata = {open_bus[7:5], joypad2_data};
		else if (sel.apu_status)
			rdata = apu_rdata;
		else if (sel.apu_cs)
			rdata = open_bus;	// Write only APU regs
		else if (sel.ppu_cs)
			rdata = ppu_rdata;
		else if (cart_drive)
			rdata = cart_rdata;
		else
			rdata = open_bus;	// Nothing drives the bus
	end

endmodule

`default_nettype wire

// ==== testbench/nes_bus_stimulus.txt ====
# op addr data expected (hex). cfg: data=sys_type, exp=clk in ten CPU cycles
# write: exp={ppu_write,prg_write} pulses, 4016 exp={lr3d,joypad_out}; dma: data=page
cfg 0000 00 78
write 2001 5a 10
write 2006 3c 10
write 8000 a5 01
write 6123 11 01
read 2002 c3 c3
read 4016 1f df
read 4015 42 42
read 4016 05 45
read 5000 99 45
read 0123 00 22
read 5000 00 22
write 4016 07 f
write 4016 02 a
write 4016 05 5
oam_dma 0000 02 100
dmc c000 07 100
cfg 0000 01 80
write 2003 00 10
write 8000 00 01
oam_dma 0000 03 100
dmc d000 05 100
read 4015 81 81
cfg 0000 00 78

// ==== testbench/nes_bus_tb.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// NES bus testbench
// Runs the stimulus file against the bus core
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module nes_bus_tb;
	import nes_bus_pkg::*;

	localparam int MAX_OPS = 64;
	localparam int WORST_CYCLE = CPU_DIV + 4;	// Long PAL cycle in clk

	logic clk, reset, cpu_rnw, dmc_request, cart_drive;
	sys_type_e sys_type;
	cpu_addr_t cpu_addr, dmc_addr, bus_addr;
	byte_t cpu_wdata, ppu_rdata, apu_rdata, cart_rdata, bus_wdata, cpu_rdata;
	logic [4:0] joypad1_data, joypad2_data;
	logic cpu_ce, ppu_ce, cart_ce, odd_cycle, pause_cpu, dmc_ack;
	logic ppu_read, ppu_write, prg_read, prg_write, lr3d;
	logic [2:0] joypad_out;
	logic [1:0] joypad_clock;

	byte_t ppu_val, apu_val, cart_val;	// Device model data
	logic [4:0] joy_val;
	integer seed;
	int errors, checks, cycle_count, cycle_limit;
	int n_ops;
	int op_code [MAX_OPS];		// 0 cfg, 1 read, 2 write, 3 oam_dma, 4 dmc
	int op_addr [MAX_OPS], op_data [MAX_OPS], op_exp [MAX_OPS];
	int ppu_cnt, prg_cnt, ppu_rd_cnt, prg_rd_cnt, ack_cnt, wr_cnt;
	bit joy0_seen, joy1_seen, pause_seen, ack_seen, watch;
	byte_t page;

	nes_bus_top uut (.*);

	initial clk = 1'b0;
	always #2 clk = ~clk;

	// RAM below 2000 is addr low xor page, cart answers from 6000 up
	always_comb begin
		ppu_rdata    = ppu_val;
		apu_rdata    = apu_val;
		joypad1_data = joy_val;
		joypad2_data = ~joy_val;
		cart_drive   = (bus_addr < 16'h2000) || (bus_addr >= 16'h6000);
		cart_rdata   = (bus_addr < 16'h2000) ? (bus_addr[7:0] ^ bus_addr[15:8]) : cart_val;
	end

	task automatic check_value(input string name, input int exp, input int act);
		checks++;
		assert (exp == act) else begin
			errors++;
			$display("FAILED %s expected %0h actual %0h", name, exp, act);
		end
	endtask

	// Sprite writes to the OAM port, in order
	always @(posedge clk) begin
		cycle_count++;
		if (watch && ppu_write && ppu_ce) begin
			check_value($sformatf("oam write %0d addr", wr_cnt), ADDR_OAM_DATA, bus_addr);
			check_value($sformatf("oam write %0d data", wr_cnt), wr_cnt[7:0] ^ page, bus_wdata);
			wr_cnt++;
		end
		if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
			$display("Timeout after %0d clk cycles, the DUT stopped responding", cycle_count);
			$display(">>> FAIL");
			$finish;
		end
	end

	// One CPU cycle, ends on the clk that carries cpu_ce
	task automatic measure_cycle();
		ppu_cnt = 0;
		prg_cnt = 0;
		ppu_rd_cnt = 0;
		prg_rd_cnt = 0;
		joy0_seen = 0;
		joy1_seen = 0;
		ack_seen = 0;
		do begin
			@(posedge clk);
			if (ppu_write && ppu_ce) ppu_cnt++;
			if (prg_write && cart_ce) prg_cnt++;
			if (ppu_read && ppu_ce) ppu_rd_cnt++;
			if (prg_read && cart_ce) prg_rd_cnt++;
			if (joypad_clock[0]) joy0_seen = 1;
			if (joypad_clock[1]) joy1_seen = 1;
		end while (!cpu_ce);
		pause_seen = pause_cpu;		// Level during the cycle
		if (dmc_ack) begin
			ack_seen = 1;
			ack_cnt++;
			check_value("dmc ack addr", dmc_addr, bus_addr);
		end
	endtask

	task automatic cpu_cycle(input cpu_addr_t a, input byte_t d, input logic rnw);
		@(negedge clk);
		cpu_addr  = a;
		cpu_wdata = d;
		cpu_rnw   = rnw;
		measure_cycle();
	endtask

	task automatic run_cfg(input string name, input int d, input int e);
		int gaps [10];
		int gap, ppu_gap, sum;
		bit prev_odd;
		@(negedge clk);
		sys_type = sys_type_e'(d[0]);
		do @(posedge clk); while (!cpu_ce);
		prev_odd = odd_cycle;
		ppu_gap = 0;
		sum = 0;
		for (int i = 0; i < 10; i++) begin
			gap = 0;
			do begin
				@(posedge clk);
				gap++;
				ppu_gap++;
				if (gap == 1) check_value({name, " odd toggle"}, !prev_odd, odd_cycle);
				if (ppu_ce || ppu_gap > PPU_DIV) begin
					check_value({name, " ppu_ce gap"}, PPU_DIV, ppu_gap);
					ppu_gap = 0;
				end
			end while (!cpu_ce);
			prev_odd = odd_cycle;
			gaps[i] = gap;
			sum += gap;
			checks++;
			assert (gap == CPU_DIV || gap == WORST_CYCLE) else begin
				errors++;
				$display("%s: CPU cycle of %0d clk is neither short nor long", name, gap);
			end
		end
		for (int i = 0; i < 5; i++)
			check_value({name, " gap period"}, gaps[i], gaps[i + 5]);	// Five cycle pattern
		check_value({name, " ten cycles"}, e, sum);
	endtask

	task automatic run_read(input string name, input cpu_addr_t a, input int d, input int e);
		int ppu_exp;
		int prg_exp;
		@(negedge clk);
		ppu_val  = $random(seed);	// Background for devices not addressed
		apu_val  = $random(seed);
		cart_val = $random(seed);
		joy_val  = $random(seed);
		if (a >= PPU_BASE && a <= PPU_END) ppu_val = d;
		if (a == ADDR_APU_STATUS) apu_val = d;
		if (a == ADDR_JOY1) joy_val = d[4:0];
		if (a >= 16'h6000) cart_val = d;
		// One read strobe per CPU cycle for the device that owns the address
		ppu_exp = (a >= PPU_BASE && a <= PPU_END);
		prg_exp = !(a >= PPU_BASE && a <= PPU_END) && !(a >= APU_BASE && a <= APU_END);
		cpu_addr = a;
		cpu_rnw  = 1'b1;
		measure_cycle();
		check_value({name, " rdata"}, e, cpu_rdata);
		check_value({name, " ppu_read"}, ppu_exp, ppu_rd_cnt);
		check_value({name, " prg_read"}, prg_exp, prg_rd_cnt);
		if (a == ADDR_JOY1)
			check_value({name, " joypad_clock"}, 2'b01, {joy1_seen, joy0_seen});
	endtask

	task automatic run_write(input string name, input cpu_addr_t a, input int d, input int e);
		cpu_cycle(a, d, 1'b0);
		if (a == ADDR_JOY1) begin
			check_value({name, " joypad reg"}, e, {lr3d, joypad_out});
			check_value({name, " strobes"}, 0, {ppu_cnt[3:0], prg_cnt[3:0]});
		end else
			check_value({name, " strobes"}, e, {ppu_cnt[3:0], prg_cnt[3:0]});
	endtask

	// Sprite DMA from page d, optionally with one DMC steal at address a
	task automatic run_dma(input string name, input bit steal, input cpu_addr_t a,
			input int d, input int e);
		int busy;
		bit requested;
		page = d;
		wr_cnt = 0;
		ack_cnt = 0;
		busy = 0;
		requested = 0;
		dmc_addr = a;
		watch = 1;
		cpu_cycle(ADDR_OAM_DMA, d, 1'b0);
		do begin
			@(negedge clk);
			if (steal && !requested && wr_cnt >= 20) begin
				dmc_request = 1'b1;
				requested = 1;
			end
			cpu_addr = 16'h8000;
			cpu_rnw  = 1'b1;
			measure_cycle();
			if (ack_seen) begin
				@(negedge clk);
				dmc_request = 1'b0;
			end
			if (busy == 0) check_value({name, " pause rise"}, 1, pause_seen);
			if (pause_seen) busy++;
		end while (pause_seen);
		watch = 0;
		check_value({name, " write count"}, e, wr_cnt);
		check_value({name, " dmc acks"}, steal, ack_cnt);
		checks++;
		assert (busy >= 513 + 2 * ack_cnt && busy <= 514 + 2 * ack_cnt) else begin
			errors++;
			$display("%s: CPU paused for %0d cycles, outside the DMA latency", name, busy);
		end
	endtask

	task automatic load_stimulus();
		int fd, a, d, e;
		string line;
		logic [63:0] word;
		n_ops = 0;
		fd = $fopen("testbench/nes_bus_stimulus.txt", "r");
		if (fd == 0) begin
			errors++;
			$display("Stimulus file could not be opened");
		end else begin
			while (!$feof(fd) && n_ops < MAX_OPS) begin
				line = "";
				void'($fgets(line, fd));
				if (line.len() < 2 || line[0] == "#") continue;	// Blank or comment
				if ($sscanf(line, "%s %h %h %h", word, a, d, e) != 4) continue;
				op_code[n_ops] = (word == "cfg") ? 0 : (word == "read") ? 1 :
					(word == "write") ? 2 : (word == "oam_dma") ? 3 :
					(word == "dmc") ? 4 : -1;
				op_addr[n_ops] = a;
				op_data[n_ops] = d;
				op_exp[n_ops]  = e;
				cycle_limit += (op_code[n_ops] >= 3) ? 530 : (op_code[n_ops] == 0) ? 12 : 2;
				n_ops++;
			end
			$fclose(fd);
		end
		cycle_limit = cycle_limit * WORST_CYCLE + 500;	// Margin covers reset and sync
	endtask

	initial begin
		string name;
		seed = 32'h97f2_d86a;
		reset = 1'b1;
		sys_type = sys_ntsc;
		cpu_addr = 16'h8000;
		cpu_wdata = 8'h00;
		cpu_rnw = 1'b1;
		dmc_request = 1'b0;
		dmc_addr = 16'hC000;
		ppu_val = 8'h00;
		apu_val = 8'h00;
		cart_val = 8'h00;
		joy_val = 5'h00;
		watch = 0;
		errors = 0;
		checks = 0;
		cycle_count = 0;
		cycle_limit = 0;
		load_stimulus();
		repeat (5) @(negedge clk);
		reset = 1'b0;
		// Everything low except odd_cycle
		check_value("reset state", 9'b0_0000_0001,
			{pause_cpu, dmc_ack, ppu_write, prg_write, joypad_out, lr3d, odd_cycle});
		do @(posedge clk); while (!cpu_ce);	// Align to a CPU cycle
		for (int i = 0; i < n_ops; i++) begin
			name = $sformatf("op %0d", i);
			case (op_code[i])
				0: run_cfg(name, op_data[i], op_exp[i]);
				1: run_read(name, op_addr[i], op_data[i], op_exp[i]);
				2: run_write(name, op_addr[i], op_data[i], op_exp[i]);
				3: run_dma(name, 0, op_addr[i], op_data[i], op_exp[i]);
				4: run_dma(name, 1, op_addr[i], op_data[i], op_exp[i]);
				default: begin
					errors++;
					$display("%s: unknown operation in the stimulus file", name);
				end
			endcase
		end
		$display("Checks: %0d  errors: %0d", checks, errors);
		if (errors == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule

`default_nettype wire
